// ==== source/ghost_pkg.sv ====
`default_nettype none

package ghost_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // grid geometry
    ////////////////////////////////////////////////////////////////////////////

    // tile coordinates and pixel edges share one width
    localparam int coord_w = 10;

    // pixels per tile side
    localparam logic [coord_w-1:0] tile_px = 10;

    ////////////////////////////////////////////////////////////////////////////
    // shared types
    ////////////////////////////////////////////////////////////////////////////

    // ghost heading, up means y decreases and left means x decreases
    typedef enum logic [2:0] {
        dir_none  = 3'd0,
        dir_up    = 3'd1,
        dir_left  = 3'd2,
        dir_down  = 3'd3,
        dir_right = 3'd4
    } dir_t;

    // hold or chase, follows the run switch
    typedef enum logic [0:0] {
        mode_hold  = 1'b0,
        mode_chase = 1'b1
    } mode_t;

    // open flags of the four neighbor tiles
    typedef struct packed {
        logic up;
        logic left;
        logic down;
        logic right;
    } open_t;

endpackage

`default_nettype wire

// ==== source/maze_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module maze_map #(
    parameter logic [ghost_pkg::coord_w-1:0] max_x = 62,
    parameter logic [ghost_pkg::coord_w-1:0] max_y = 46
) (
    input  wire logic [ghost_pkg::coord_w-1:0] ghost_x,
    input  wire logic [ghost_pkg::coord_w-1:0] ghost_y,
    output ghost_pkg::open_t                   open
);

    // bordered grid with pillars on every even/even tile
    function automatic logic tile_open(
        input logic [ghost_pkg::coord_w-1:0] x,
        input logic [ghost_pkg::coord_w-1:0] y
    );
        logic in_range;
        in_range = (x >= 1) && (x <= max_x) && (y >= 1) && (y <= max_y);
        return in_range && (x[0] || y[0]);
    endfunction

    // neighbor coordinates, a wrap below zero lands out of range
    logic [ghost_pkg::coord_w-1:0] x_dec;
    logic [ghost_pkg::coord_w-1:0] x_inc;
    logic [ghost_pkg::coord_w-1:0] y_dec;
    logic [ghost_pkg::coord_w-1:0] y_inc;

    assign x_dec = ghost_x - 1'b1;
    assign x_inc = ghost_x + 1'b1;
    assign y_dec = ghost_y - 1'b1;
    assign y_inc = ghost_y + 1'b1;

    always_comb begin
        open.up    = tile_open(ghost_x, y_dec);
        open.left  = tile_open(x_dec, ghost_y);
        open.down  = tile_open(ghost_x, y_inc);
        open.right = tile_open(x_inc, ghost_y);
    end

endmodule

`default_nettype wire

// ==== source/chase_decide.sv ====
`timescale 1ns/1ps
`default_nettype none

module chase_decide (
    input  wire logic [ghost_pkg::coord_w-1:0] ghost_x,
    input  wire logic [ghost_pkg::coord_w-1:0] ghost_y,
    input  wire logic [ghost_pkg::coord_w-1:0] pac_x,
    input  wire logic [ghost_pkg::coord_w-1:0] pac_y,
    input  wire ghost_pkg::dir_t               heading,
    input  wire ghost_pkg::open_t              open,
    output ghost_pkg::dir_t                    next_dir
);

    // dir_none is never open
    function automatic logic dir_open(
        input ghost_pkg::dir_t  d,
        input ghost_pkg::open_t o
    );
        case (d)
            ghost_pkg::dir_up:    return o.up;
            ghost_pkg::dir_left:  return o.left;
            ghost_pkg::dir_down:  return o.down;
            ghost_pkg::dir_right: return o.right;
            default:              return 1'b0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // distance and wanted direction on each axis
    ////////////////////////////////////////////////////////////////////////////

    logic [ghost_pkg::coord_w-1:0] dist_x;
    logic [ghost_pkg::coord_w-1:0] dist_y;
    ghost_pkg::dir_t               h_dir;
    ghost_pkg::dir_t               v_dir;
    logic                          h_ok;
    logic                          v_ok;
    logic                          vert_first;

    assign dist_x = (pac_x > ghost_x) ? pac_x - ghost_x : ghost_x - pac_x;
    assign dist_y = (pac_y > ghost_y) ? pac_y - ghost_y : ghost_y - pac_y;

    always_comb begin
        if (pac_x > ghost_x) begin
            h_dir = ghost_pkg::dir_right;
        end else if (pac_x < ghost_x) begin
            h_dir = ghost_pkg::dir_left;
        end else begin
            h_dir = ghost_pkg::dir_none;
        end
        if (pac_y > ghost_y) begin
            v_dir = ghost_pkg::dir_down;
        end else if (pac_y < ghost_y) begin
            v_dir = ghost_pkg::dir_up;
        end else begin
            v_dir = ghost_pkg::dir_none;
        end
    end

    // zero distance gives dir_none, so the ok flags cover both conditions
    assign h_ok       = dir_open(h_dir, open);
    assign v_ok       = dir_open(v_dir, open);
    assign vert_first = (dist_y >= dist_x);

    ////////////////////////////////////////////////////////////////////////////
    // priority pick
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (vert_first && v_ok) begin
            next_dir = v_dir;
        end else if (h_ok) begin
            next_dir = h_dir;
        end else if (v_ok) begin
            next_dir = v_dir;
        end else if (dir_open(heading, open)) begin
            next_dir = heading;
        end else if (open.up) begin
            next_dir = ghost_pkg::dir_up;
        end else if (open.left) begin
            next_dir = ghost_pkg::dir_left;
        end else if (open.down) begin
            next_dir = ghost_pkg::dir_down;
        end else if (open.right) begin
            next_dir = ghost_pkg::dir_right;
        end else begin
            next_dir = ghost_pkg::dir_none;
        end
    end

endmodule

`default_nettype wire

// ==== source/step_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_timer #(
    parameter int step_cycles = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic timer_en,
    output logic      step_tick
);

    localparam int cnt_w = (step_cycles > 1) ? $clog2(step_cycles) : 1;
    localparam logic [cnt_w-1:0] last = cnt_w'(step_cycles - 1);

    logic [cnt_w-1:0] count;

    // tick is registered, so it follows the wrap by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            count     <= '0;
            step_tick <= 1'b0;
        end else if (!timer_en) begin
            count     <= '0;
            step_tick <= 1'b0;
        end else if (count == last) begin
            count     <= '0;
            step_tick <= 1'b1;
        end else begin
            count     <= count + 1'b1;
            step_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/ghost_mode_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghost_mode_fsm (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic run,
    input  wire logic step_tick,
    output logic      timer_en,
    output logic      advance
);

    ghost_pkg::mode_t state;
    ghost_pkg::mode_t state_next;

    // state tracks the run switch one cycle late
    always_comb begin
        if (run) begin
            state_next = ghost_pkg::mode_chase;
        end else begin
            state_next = ghost_pkg::mode_hold;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ghost_pkg::mode_hold;
        end else begin
            state <= state_next;
        end
    end

    // timer only runs while chasing, a drop to hold restarts the latency
    assign timer_en = (state == ghost_pkg::mode_chase);

    // a tick left over from the last chase cycle must not step
    assign advance = timer_en && step_tick;

endmodule

`default_nettype wire

// ==== source/ghost_mover.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghost_mover #(
    parameter logic [ghost_pkg::coord_w-1:0] start_x = 39,
    parameter logic [ghost_pkg::coord_w-1:0] start_y = 27
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          advance,
    input  wire ghost_pkg::dir_t               next_dir,
    output logic [ghost_pkg::coord_w-1:0]      ghost_x,
    output logic [ghost_pkg::coord_w-1:0]      ghost_y,
    output ghost_pkg::dir_t                    heading,
    output logic [ghost_pkg::coord_w-1:0]      ghost_left,
    output logic [ghost_pkg::coord_w-1:0]      ghost_top_px,
    output logic [ghost_pkg::coord_w-1:0]      ghost_right,
    output logic [ghost_pkg::coord_w-1:0]      ghost_bottom
);

    ////////////////////////////////////////////////////////////////////////////
    // tile position and heading
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ghost_x <= start_x;
            ghost_y <= start_y;
            heading <= ghost_pkg::dir_right;
        end else if (advance) begin
            heading <= next_dir;
            case (next_dir)
                ghost_pkg::dir_up:    ghost_y <= ghost_y - 1'b1;
                ghost_pkg::dir_left:  ghost_x <= ghost_x - 1'b1;
                ghost_pkg::dir_down:  ghost_y <= ghost_y + 1'b1;
                ghost_pkg::dir_right: ghost_x <= ghost_x + 1'b1;
                default: begin
                    // dir_none keeps the ghost in place
                    ghost_x <= ghost_x;
                    ghost_y <= ghost_y;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // pixel bounding box
    ////////////////////////////////////////////////////////////////////////////

    // tile n covers pixels tile_px*(n-1) up to tile_px*n
    assign ghost_right  = ghost_pkg::tile_px * ghost_x;
    assign ghost_bottom = ghost_pkg::tile_px * ghost_y;
    assign ghost_left   = ghost_right - ghost_pkg::tile_px;
    assign ghost_top_px = ghost_bottom - ghost_pkg::tile_px;

endmodule

`default_nettype wire

// ==== source/ghost_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghost_top #(
    parameter int                            step_cycles = 4,
    parameter logic [ghost_pkg::coord_w-1:0] max_x       = 62,
    parameter logic [ghost_pkg::coord_w-1:0] max_y       = 46,
    parameter logic [ghost_pkg::coord_w-1:0] start_x     = 39,
    parameter logic [ghost_pkg::coord_w-1:0] start_y     = 27
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          run,
    input  wire logic [ghost_pkg::coord_w-1:0] pac_x,
    input  wire logic [ghost_pkg::coord_w-1:0] pac_y,
    output logic [ghost_pkg::coord_w-1:0]      ghost_left,
    output logic [ghost_pkg::coord_w-1:0]      ghost_top_px,
    output logic [ghost_pkg::coord_w-1:0]      ghost_right,
    output logic [ghost_pkg::coord_w-1:0]      ghost_bottom,
    output ghost_pkg::dir_t                    heading
);

    logic                          timer_en;
    logic                          step_tick;
    logic                          advance;
    logic [ghost_pkg::coord_w-1:0] ghost_x;
    logic [ghost_pkg::coord_w-1:0] ghost_y;
    ghost_pkg::open_t              open;
    ghost_pkg::dir_t               next_dir;

    // pacing
    ghost_mode_fsm u_mode (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .step_tick (step_tick),
        .timer_en  (timer_en),
        .advance   (advance)
    );

    step_timer #(.step_cycles(step_cycles)) u_timer (
        .clk       (clk),
        .rst       (rst),
        .timer_en  (timer_en),
        .step_tick (step_tick)
    );

    // decision path, combinational from the position registers
    maze_map #(.max_x(max_x), .max_y(max_y)) u_map (
        .ghost_x (ghost_x),
        .ghost_y (ghost_y),
        .open    (open)
    );

    chase_decide u_decide (
        .ghost_x  (ghost_x),
        .ghost_y  (ghost_y),
        .pac_x    (pac_x),
        .pac_y    (pac_y),
        .heading  (heading),
        .open     (open),
        .next_dir (next_dir)
    );

    ghost_mover #(.start_x(start_x), .start_y(start_y)) u_mover (
        .clk          (clk),
        .rst          (rst),
        .advance      (advance),
        .next_dir     (next_dir),
        .ghost_x      (ghost_x),
        .ghost_y      (ghost_y),
        .heading      (heading),
        .ghost_left   (ghost_left),
        .ghost_top_px (ghost_top_px),
        .ghost_right  (ghost_right),
        .ghost_bottom (ghost_bottom)
    );

endmodule

`default_nettype wire

// ==== test/ghost_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghost_assert #(
    parameter int max_x = 62,
    parameter int max_y = 46
) (
    input wire logic                          clk,
    input wire logic                          rst,
    input wire logic                          advance,
    input wire logic [ghost_pkg::coord_w-1:0] ghost_x,
    input wire logic [ghost_pkg::coord_w-1:0] ghost_y
);

    int x;
    int y;

    assign x = int'(ghost_x);
    assign y = int'(ghost_y);

    // squared step length of at most one means one axis by one tile, or no move
    one_tile_step: assert property (@(posedge clk) disable iff (rst)
        advance |=> ((x - $past(x)) * (x - $past(x)) + (y - $past(y)) * (y - $past(y))) <= 1)
        else $error("ghost moved more than one tile on a single advance");

    no_drift: assert property (@(posedge clk) disable iff (rst)
        !advance |=> ($stable(x) && $stable(y)))
        else $error("ghost position changed without an advance pulse");

    on_open_tile: assert property (@(posedge clk) disable iff (rst)
        (x >= 1 && x <= max_x && y >= 1 && y <= max_y && (x % 2 == 1 || y % 2 == 1)))
        else $error("ghost sits on a pillar or outside the grid");

endmodule

bind ghost_mover ghost_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .advance (advance),
    .ghost_x (ghost_x),
    .ghost_y (ghost_y)
);

`default_nettype wire

// ==== test/ghost_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ghost_tb;

    localparam int clk_period  = 20;
    localparam int step_cycles = 4;
    localparam int max_x       = 62;
    localparam int max_y       = 46;
    localparam int start_x     = 39;
    localparam int start_y     = 27;
    localparam int tile        = int'(ghost_pkg::tile_px);

    logic                          clk;
    logic                          rst;
    logic                          run;
    logic [ghost_pkg::coord_w-1:0] pac_x;
    logic [ghost_pkg::coord_w-1:0] pac_y;
    logic [ghost_pkg::coord_w-1:0] ghost_left;
    logic [ghost_pkg::coord_w-1:0] ghost_top_px;
    logic [ghost_pkg::coord_w-1:0] ghost_right;
    logic [ghost_pkg::coord_w-1:0] ghost_bottom;
    ghost_pkg::dir_t               heading;

    int              errors;
    int              checks;
    int              model_x;
    int              model_y;
    ghost_pkg::dir_t model_dir;
    logic [31:0]     seed;
    logic            table_ready;
    int              total_steps;
    int              n_entries;
    logic            tab_run[32];
    int              tab_px[32];
    int              tab_py[32];
    int              tab_steps[32];

    ghost_top #(
        .step_cycles (step_cycles),
        .max_x       (10'(max_x)),
        .max_y       (10'(max_y)),
        .start_x     (10'(start_x)),
        .start_y     (10'(start_y))
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .pac_x        (pac_x),
        .pac_y        (pac_y),
        .ghost_left   (ghost_left),
        .ghost_top_px (ghost_top_px),
        .ghost_right  (ghost_right),
        .ghost_bottom (ghost_bottom),
        .heading      (heading)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model of the maze and the chase rule
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic tile_open(input int x, input int y);
        return x >= 1 && x <= max_x && y >= 1 && y <= max_y && (x % 2 == 1 || y % 2 == 1);
    endfunction

    function automatic int step_dx(input ghost_pkg::dir_t d);
        return (d == ghost_pkg::dir_right) ? 1 : (d == ghost_pkg::dir_left) ? -1 : 0;
    endfunction

    function automatic int step_dy(input ghost_pkg::dir_t d);
        return (d == ghost_pkg::dir_down) ? 1 : (d == ghost_pkg::dir_up) ? -1 : 0;
    endfunction

    // candidates in priority order and the first open one wins
    function automatic ghost_pkg::dir_t chase_pick(input int gx, input int gy, input int px,
                                                   input int py, input ghost_pkg::dir_t cur);
        ghost_pkg::dir_t cand[7];
        ghost_pkg::dir_t want_x;
        ghost_pkg::dir_t want_y;
        int              dist_x;
        int              dist_y;
        want_x = (px > gx) ? ghost_pkg::dir_right : (px < gx) ? ghost_pkg::dir_left
                                                              : ghost_pkg::dir_none;
        want_y = (py > gy) ? ghost_pkg::dir_down : (py < gy) ? ghost_pkg::dir_up
                                                             : ghost_pkg::dir_none;
        dist_x = (px > gx) ? px - gx : gx - px;
        dist_y = (py > gy) ? py - gy : gy - py;
        // a tie makes the vertical axis primary
        cand[0] = (dist_y >= dist_x) ? want_y : want_x;
        cand[1] = (dist_y >= dist_x) ? want_x : want_y;
        cand[2] = cur;
        cand[3] = ghost_pkg::dir_up;
        cand[4] = ghost_pkg::dir_left;
        cand[5] = ghost_pkg::dir_down;
        cand[6] = ghost_pkg::dir_right;
        for (int i = 0; i < 7; i++) begin
            if (cand[i] != ghost_pkg::dir_none &&
                tile_open(gx + step_dx(cand[i]), gy + step_dy(cand[i]))) begin
                return cand[i];
            end
        end
        return ghost_pkg::dir_none;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h expected 0x%h at %0t", name, got, expected,
                     $time);
        end
    endtask

    // box edges follow from the model tile
    task automatic check_box();
        compare_value("ghost_left", 32'(ghost_left), tile * model_x - tile);
        compare_value("ghost_top_px", 32'(ghost_top_px), tile * model_y - tile);
        compare_value("ghost_right", 32'(ghost_right), tile * model_x);
        compare_value("ghost_bottom", 32'(ghost_bottom), tile * model_y);
        compare_value("heading", 32'(heading), 32'(model_dir));
    endtask

    task automatic add_entry(input logic r, input int px, input int py, input int n);
        tab_run[n_entries]   = r;
        tab_px[n_entries]    = px;
        tab_py[n_entries]    = py;
        tab_steps[n_entries] = n;
        total_steps += n;
        n_entries++;
    endtask

    task automatic build_table();
        n_entries   = 0;
        total_steps = 0;
        seed        = 32'h9f0a_ca06;
        // run, pac_x, pac_y, steps (hold entries wait steps times step_cycles)
        add_entry(1'b0, 0, 0, 5);
        add_entry(1'b1, 45, 27, 9);
        add_entry(1'b1, 44, 20, 8);
        add_entry(1'b0, 44, 20, 3);
        add_entry(1'b1, 10, 40, 10);
        add_entry(1'b1, 0, 0, 40);
        add_entry(1'b0, 0, 0, 2);
        add_entry(1'b1, 63, 47, 12);
        add_entry(1'b1, 1023, 5, 8);
        for (int k = 0; k < 8; k++) begin
            seed = lcg_next(seed);
            add_entry(1'b1, int'((seed >> 8) % 32'(max_x + 2)),
                      int'((seed >> 20) % 32'(max_y + 2)), 6);
        end
    endtask

    // predict before the step edge, then wait for the box to move
    task automatic wait_step(input int expect_gap);
        int              gap;
        int              old_right;
        int              old_bottom;
        logic            moved;
        ghost_pkg::dir_t pick;
        old_right  = int'(ghost_right);
        old_bottom = int'(ghost_bottom);
        pick       = chase_pick(model_x, model_y, int'(pac_x), int'(pac_y), model_dir);
        gap        = 0;
        moved      = 1'b0;
        while (!moved && gap < expect_gap + step_cycles) begin
            @(negedge clk);
            gap++;
            moved = (int'(ghost_right) != old_right) || (int'(ghost_bottom) != old_bottom);
        end
        if (!moved) begin
            errors++;
            $display("ghost did not move within %0d cycles at %0t", gap, $time);
        end else begin
            compare_value("step_gap", gap, expect_gap);
            model_x   = model_x + step_dx(pick);
            model_y   = model_y + step_dy(pick);
            model_dir = pick;
            check_box();
        end
    endtask

    initial begin
        logic prev_run;
        int   expect_gap;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        rst         = 1'b1;
        run         = 1'b0;
        pac_x       = '0;
        pac_y       = '0;
        model_x     = start_x;
        model_y     = start_y;
        model_dir   = ghost_pkg::dir_right;
        prev_run    = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_box();
        for (int i = 0; i < n_entries; i++) begin
            run   = tab_run[i];
            pac_x = 10'(tab_px[i]);
            pac_y = 10'(tab_py[i]);
            if (!tab_run[i]) begin
                repeat (tab_steps[i] * step_cycles) @(negedge clk);
                check_box();
            end else begin
                // the gap counts falling edges from the drive edge and adds one to the latency
                expect_gap = prev_run ? step_cycles : step_cycles + 2;
                for (int s = 0; s < tab_steps[i]; s++) begin
                    wait_step(expect_gap);
                    expect_gap = step_cycles;
                end
            end
            prev_run = tab_run[i];
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // one step period per table step, the start latency per entry, and a margin
    initial begin
        int limit;
        wait (table_ready);
        limit = total_steps * step_cycles + n_entries * (step_cycles + 2) + 50;
        #(limit * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/ghost_pkg.sv
source/maze_map.sv
source/chase_decide.sv
source/step_timer.sv
source/ghost_mode_fsm.sv
source/ghost_mover.sv
source/ghost_top.sv
test/ghost_assert.sv
test/ghost_tb.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vghost_tb: verilog.f $(wildcard source/*.sv test/*.sv)
	verilator --binary --timing --assert -f verilog.f --top-module ghost_tb -o Vghost_tb

run: obj_dir/Vghost_tb
	@out="$$(./obj_dir/Vghost_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
